// File: src/source_pkg.sv
// shared widths, config/flag structs, memory port structs and fsm state enum
package source_pkg;

  // transaction counter width, caps a run at 2^16 wide words
  localparam int unsigned TRANS_CNT_W = 16;

  // bytes per bank word
  localparam int unsigned BANK_BYTES = 4;

  typedef logic [31:0] addr_t; // byte address
  typedef logic [31:0] word_t; // one bank word
  typedef logic [TRANS_CNT_W-1:0] cnt_t;

  // controller states
  typedef enum logic {
    ST_IDLE    = 1'b0,
    ST_WORKING = 1'b1
  } state_e;

  // run configuration, held stable by the host while busy
  typedef struct packed {
    addr_t base_addr;   // byte address of port 0, word 0
    cnt_t  trans_size;  // number of wide words
    addr_t word_stride; // bytes between wide words
  } source_cfg_t;

  // status back to the host
  typedef struct packed {
    logic ready_start; // idle, start accepted
    logic done;        // one cycle after the last request
    logic in_progress; // address pattern still running
  } source_flags_t;

  // one bank port request, read only
  typedef struct packed {
    logic  req;
    addr_t addr;
  } mem_req_t;

  // one bank port response
  typedef struct packed {
    logic  gnt;     // same cycle as req
    logic  r_valid; // one cycle after gnt
    word_t r_data;
  } mem_rsp_t;

endpackage

// File: src/source_addrgen.sv
// strided address walker with word counter and last flag
module source_addrgen #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  logic                    advance_i,
  input  source_pkg::source_cfg_t cfg_i,
  output source_pkg::addr_t       addr_o,
  output logic                    last_o,
  output logic                    in_progress_o
);

  source_pkg::addr_t addr_q;
  source_pkg::cnt_t  cnt_q;    // index of the current wide word
  source_pkg::cnt_t  last_idx;
  logic              running_q;
  logic              load;

  // new run only once the previous pattern is finished
  assign load     = start_i & ~running_q;
  assign last_idx = cfg_i.trans_size - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q    <= '0;
      cnt_q     <= '0;
      running_q <= 1'b0;
    end else if (load) begin
      addr_q    <= cfg_i.base_addr;
      cnt_q     <= '0;
      running_q <= 1'b1;
    end else if (advance_i && running_q) begin
      addr_q <= addr_q + cfg_i.word_stride; // next wide word
      cnt_q  <= cnt_q + 1'b1;
      if (last_o) begin
        running_q <= 1'b0; // final word accepted
      end
    end
  end

  assign addr_o        = addr_q;
  assign last_o        = running_q && (cnt_q == last_idx);
  assign in_progress_o = running_q;

endmodule

// File: src/source_ctrl.sv
// source_ctrl: idle/working fsm, per-port grant fence, request and done pulse
module source_ctrl #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                start_i,
  input  logic                                stream_ready_i,
  input  source_pkg::addr_t                   addr_i,
  input  logic                                last_i,
  input  source_pkg::mem_rsp_t [NB_PORTS-1:0] mem_rsp_i,
  output source_pkg::mem_req_t [NB_PORTS-1:0] mem_req_o,
  output logic                                advance_o,
  output logic                                ready_start_o,
  output logic                                done_o
);

  source_pkg::state_e state_q, state_d;

  logic [NB_PORTS-1:0] fence_q;   // ports already granted for this word
  logic [NB_PORTS-1:0] port_req;
  logic [NB_PORTS-1:0] port_done; // granted now or earlier
  logic                issue;     // requests allowed this cycle
  logic                word_done; // every port granted
  logic                done_q;

  // no new requests while the consumer stalls
  assign issue = (state_q == source_pkg::ST_WORKING) & stream_ready_i;

  for (genvar p = 0; p < NB_PORTS; p++) begin : g_port
    assign port_req[p]  = issue & ~fence_q[p];
    assign port_done[p] = fence_q[p] | (port_req[p] & mem_rsp_i[p].gnt);

    // port p reads the p-th bank word of the wide word
    assign mem_req_o[p].req  = port_req[p];
    assign mem_req_o[p].addr = addr_i + source_pkg::addr_t'(p * source_pkg::BANK_BYTES);
  end

  assign word_done = issue & (&port_done);
  assign advance_o = word_done;

  // fence: remember grants until the whole word is through
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fence_q <= '0;
    end else if (word_done) begin
      fence_q <= '0;
    end else begin
      fence_q <= fence_q | (port_req & port_done);
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      source_pkg::ST_IDLE: begin
        if (start_i) state_d = source_pkg::ST_WORKING;
      end
      source_pkg::ST_WORKING: begin
        if (word_done && last_i) state_d = source_pkg::ST_IDLE; // last word out
      end
      default: state_d = source_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= source_pkg::ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= word_done & last_i; // lands with the return to idle
    end
  end

  assign ready_start_o = (state_q == source_pkg::ST_IDLE);
  assign done_o        = done_q;

endmodule

// File: src/source_resp_capture.sv
// source_resp_capture: per-port response hold registers merged into the wide beat
module source_resp_capture #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  source_pkg::mem_rsp_t [NB_PORTS-1:0] mem_rsp_i,
  input  logic                                stream_ready_i,
  output logic                                stream_valid_o,
  output source_pkg::word_t    [NB_PORTS-1:0] stream_data_o
);

  logic              [NB_PORTS-1:0] held_valid_q;
  source_pkg::word_t [NB_PORTS-1:0] held_data_q;
  logic              [NB_PORTS-1:0] port_valid;
  logic                             beat_xfer;

  for (genvar p = 0; p < NB_PORTS; p++) begin : g_port
    // live response wins, otherwise the held copy
    assign port_valid[p]    = mem_rsp_i[p].r_valid | held_valid_q[p];
    assign stream_data_o[p] = mem_rsp_i[p].r_valid ? mem_rsp_i[p].r_data : held_data_q[p];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        held_valid_q[p] <= 1'b0;
      end else if (beat_xfer) begin
        held_valid_q[p] <= 1'b0; // consumed by the merged beat
      end else begin
        held_valid_q[p] <= port_valid[p];
      end
    end

    // payload only, valid bit qualifies it
    always_ff @(posedge clk_i) begin
      if (mem_rsp_i[p].r_valid) begin
        held_data_q[p] <= mem_rsp_i[p].r_data;
      end
    end
  end

  // beat is complete once every port has its word
  assign stream_valid_o = &port_valid;
  assign beat_xfer      = stream_valid_o & stream_ready_i;

endmodule

// File: src/source_streamer.sv
// source_streamer: top level, address generator, controller and response capture
module source_streamer #(
  parameter int unsigned NB_PORTS = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                start_i,
  input  source_pkg::source_cfg_t             cfg_i,
  output source_pkg::source_flags_t           flags_o,
  output source_pkg::mem_req_t [NB_PORTS-1:0] mem_req_o,
  input  source_pkg::mem_rsp_t [NB_PORTS-1:0] mem_rsp_i,
  output logic                                stream_valid_o,
  output source_pkg::word_t    [NB_PORTS-1:0] stream_data_o,
  input  logic                                stream_ready_i
);

  source_pkg::addr_t gen_addr;   // current wide word address
  logic              gen_last;
  logic              advance;    // all ports granted
  logic              ready_start;
  logic              done;
  logic              in_progress;

  source_addrgen #(
    .NB_PORTS ( NB_PORTS )
  ) i_addrgen (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .start_i       ( start_i     ),
    .advance_i     ( advance     ),
    .cfg_i         ( cfg_i       ),
    .addr_o        ( gen_addr    ),
    .last_o        ( gen_last    ),
    .in_progress_o ( in_progress )
  );

  source_ctrl #(
    .NB_PORTS ( NB_PORTS )
  ) i_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .start_i        ( start_i        ),
    .stream_ready_i ( stream_ready_i ),
    .addr_i         ( gen_addr       ),
    .last_i         ( gen_last       ),
    .mem_rsp_i      ( mem_rsp_i      ), // gnt only
    .mem_req_o      ( mem_req_o      ),
    .advance_o      ( advance        ),
    .ready_start_o  ( ready_start    ),
    .done_o         ( done           )
  );

  source_resp_capture #(
    .NB_PORTS ( NB_PORTS )
  ) i_capture (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .mem_rsp_i      ( mem_rsp_i      ), // r_valid and r_data
    .stream_ready_i ( stream_ready_i ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  )
  );

  // status to the host
  assign flags_o = '{
    ready_start : ready_start,
    done        : done,
    in_progress : in_progress
  };

endmodule

// File: sim/tb_source_streamer.sv
// clock, reset, banked memory model, stream monitor, compare tasks and directed tests
module tb_source_streamer;

  localparam int unsigned NB_PORTS = 2;
  localparam int          TIMEOUT  = 2000; // cycles allowed per wait

  typedef source_pkg::word_t [NB_PORTS-1:0] beat_t; // one wide output word

  localparam source_pkg::source_flags_t IDLE_FLAGS =
    '{ready_start: 1'b1, done: 1'b0, in_progress: 1'b0};
  localparam source_pkg::source_flags_t BUSY_FLAGS =
    '{ready_start: 1'b0, done: 1'b0, in_progress: 1'b1};
  localparam source_pkg::source_flags_t DONE_FLAGS =
    '{ready_start: 1'b1, done: 1'b1, in_progress: 1'b0};

  logic                                clk_i        = 1'b0;
  logic                                rst_ni       = 1'b0;
  logic                                start_i      = 1'b0;
  source_pkg::source_cfg_t             cfg_i        = '0;
  source_pkg::source_flags_t           flags;
  source_pkg::mem_req_t [NB_PORTS-1:0] mem_req;
  source_pkg::mem_rsp_t [NB_PORTS-1:0] mem_rsp      = '0;
  logic                                stream_valid;
  beat_t                               stream_data;
  logic                                stream_ready = 1'b0;

  integer seed       = 93;
  logic   rand_gnt   = 1'b0; // per-port random grants
  logic   rand_ready = 1'b0; // random consumer stalls
  beat_t  beats[$];          // beats seen on the output
  beat_t  expect_q[$];       // predicted beats, in order
  int     done_cnt   = 0;
  int     gnt_cnt[NB_PORTS]; // granted requests per port
  logic   stall_q    = 1'b0; // last edge saw valid without ready
  beat_t  stall_data = '0;

  always #20 clk_i = ~clk_i;

  source_streamer #(
    .NB_PORTS ( NB_PORTS )
  ) UUT (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .start_i        ( start_i      ),
    .cfg_i          ( cfg_i        ),
    .flags_o        ( flags        ),
    .mem_req_o      ( mem_req      ),
    .mem_rsp_i      ( mem_rsp      ),
    .stream_valid_o ( stream_valid ),
    .stream_data_o  ( stream_data  ),
    .stream_ready_i ( stream_ready )
  );

  // bank contents as a fixed function of the byte address
  function automatic source_pkg::word_t scramble(input source_pkg::addr_t a);
    return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
  endfunction

  // port p of wide word k sits at base + k*stride + p*4
  function automatic beat_t predict_beat(input source_pkg::source_cfg_t cfg, input int k);
    beat_t             b;
    source_pkg::addr_t a;
    for (int p = 0; p < NB_PORTS; p++) begin
      a    = cfg.base_addr + source_pkg::addr_t'(k) * cfg.word_stride;
      a    = a + source_pkg::addr_t'(p * source_pkg::BANK_BYTES);
      b[p] = scramble(a);
    end
    return b;
  endfunction

  function automatic source_pkg::source_cfg_t make_cfg(input source_pkg::addr_t base,
                                                       input source_pkg::cnt_t  size,
                                                       input source_pkg::addr_t stride);
    source_pkg::source_cfg_t c;
    c.base_addr   = base;
    c.trans_size  = size;
    c.word_stride = stride;
    return c;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_flags(input string name, input source_pkg::source_flags_t exp,
                             input source_pkg::source_flags_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      report_failure($sformatf("FAILED %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  // memory banks and consumer driven on the rising edge
  always @(posedge clk_i) begin : env_model
    int rnd;
    for (int p = 0; p < NB_PORTS; p++) begin
      rnd = $random(seed);
      mem_rsp[p].r_valid <= mem_req[p].req & mem_rsp[p].gnt; // one cycle after req and gnt
      mem_rsp[p].r_data  <= (mem_req[p].req & mem_rsp[p].gnt) ? scramble(mem_req[p].addr) : '0;
      mem_rsp[p].gnt     <= rand_gnt ? rnd[0] : 1'b1;
    end
    rnd = $random(seed);
    stream_ready <= rand_ready ? rnd[1] : 1'b1;
  end

  // collects beats and grants, checks stall stability and the done cycle
  always @(posedge clk_i) begin : stream_monitor
    if (rst_ni) begin
      if (stall_q) begin
        if (!stream_valid) report_failure("stream valid dropped while the consumer stalled");
        check_beat("stall_hold", stall_data, stream_data);
      end
      if (stream_valid && stream_ready) beats.push_back(stream_data);
      for (int p = 0; p < NB_PORTS; p++) begin
        if (mem_req[p].req && mem_rsp[p].gnt) gnt_cnt[p]++; // one per port and word
      end
      if (flags.done) begin
        done_cnt++;
        check_flags("done_pulse", DONE_FLAGS, flags); // idle again in the done cycle
      end
      stall_q    = stream_valid & ~stream_ready;
      stall_data = stream_data;
    end
  end

  task automatic launch_run(input string name, input source_pkg::source_cfg_t cfg);
    int i;
    for (i = 0; i < TIMEOUT; i++) begin
      if (flags.ready_start) break;
      @(posedge clk_i);
    end
    if (i == TIMEOUT) report_failure($sformatf("%s never saw ready_start", name));
    start_i <= 1'b1;
    cfg_i   <= cfg; // held until the next run
    for (int k = 0; k < int'(cfg.trans_size); k++) expect_q.push_back(predict_beat(cfg, k));
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  // busy flags hold on every cycle until done
  task automatic wait_done(input string name);
    int i;
    for (i = 0; i < TIMEOUT; i++) begin
      @(posedge clk_i);
      if (flags.done) break;
      check_flags({name, " busy"}, BUSY_FLAGS, flags);
    end
    if (i == TIMEOUT) report_failure($sformatf("%s timed out waiting for done", name));
  endtask

  task automatic drain_beats(input string name);
    int i;
    for (i = 0; i < TIMEOUT; i++) begin
      if (beats.size() >= expect_q.size()) break;
      @(posedge clk_i);
    end
    if (i == TIMEOUT) report_failure($sformatf("%s timed out waiting for beats", name));
    repeat (20) @(posedge clk_i); // room for a stray extra beat
    check_count({name, " beats"}, expect_q.size(), beats.size());
    if (stream_valid) report_failure($sformatf("%s left stream valid high", name));
    for (int b = 0; b < expect_q.size(); b++) begin
      check_beat($sformatf("%s beat %0d", name, b), expect_q[b], beats[b]);
    end
    for (int p = 0; p < NB_PORTS; p++) begin
      check_count($sformatf("%s port %0d grants", name, p), expect_q.size(), gnt_cnt[p]);
      gnt_cnt[p] = 0;
    end
    beats.delete();
    expect_q.delete();
  endtask

  task automatic after_reset();
    check_flags("after_reset", IDLE_FLAGS, flags);
    if (stream_valid) report_failure("after_reset: stream valid is high out of reset");
  endtask

  task automatic plain_run();
    rand_gnt   <= 1'b0;
    rand_ready <= 1'b0;
    done_cnt = 0;
    launch_run("plain_run", make_cfg(32'h0000_0100, 16'd8, 32'h10));
    wait_done("plain_run");
    drain_beats("plain_run");
    check_count("plain_run done pulses", 1, done_cnt);
  endtask

  // grants trickle in per port so the fence must hold one request per port
  task automatic random_grants();
    rand_gnt <= 1'b1;
    done_cnt = 0;
    launch_run("random_grants", make_cfg(32'h0000_2000, 16'd12, 32'h8));
    wait_done("random_grants");
    drain_beats("random_grants");
    check_count("random_grants done pulses", 1, done_cnt);
  endtask

  task automatic ready_toggle();
    rand_gnt   <= 1'b1;
    rand_ready <= 1'b1;
    done_cnt = 0;
    launch_run("ready_toggle", make_cfg(32'h0000_3004, 16'd16, 32'h24));
    wait_done("ready_toggle");
    drain_beats("ready_toggle");
    check_count("ready_toggle done pulses", 1, done_cnt);
  endtask

  // second start lands right after the first done
  task automatic back_to_back();
    done_cnt = 0;
    launch_run("back_to_back first", make_cfg(32'h0000_4000, 16'd6, 32'h10));
    wait_done("back_to_back first");
    launch_run("back_to_back second", make_cfg(32'h0000_5010, 16'd9, 32'hC));
    wait_done("back_to_back second");
    drain_beats("back_to_back");
    check_count("back_to_back done pulses", 2, done_cnt);
  endtask

  initial begin
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    after_reset();
    plain_run();
    random_grants();
    ready_toggle();
    back_to_back();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: list.f
src/source_pkg.sv
src/source_addrgen.sv
src/source_ctrl.sv
src/source_resp_capture.sv
src/source_streamer.sv
sim/tb_source_streamer.sv

// File: run.sh
#!/usr/bin/env bash
# builds the source streamer testbench with verilator and runs it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_source_streamer \
  -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb \
  || { echo "simulation run failed"; exit 1; }
